//--- design/tlx_config.svh
// TLX reverse channel configuration
`ifndef TLX_CONFIG_SVH
`define TLX_CONFIG_SVH

// Datapath and bus widths
`define TLX_SEQ_W   32
`define TLX_LEN_W   32
`define TLX_ADDR_W  6
`define TLX_DATA_W  32

// Register offsets within a lane
`define TLX_REG_CTRL   6'h00
`define TLX_REG_CMD    6'h04
`define TLX_REG_SEQ    6'h08
`define TLX_REG_LEN    6'h0C
`define TLX_REG_STAT   6'h10
`define TLX_REG_COUNT  6'h14

// Lane bases
`define TLX_RX_BASE  6'h00
`define TLX_TX_BASE  6'h20

// AXI response codes
`define TLX_RESP_OKAY    2'b00
`define TLX_RESP_SLVERR  2'b10

`endif

//--- design/tlx_csr.sv
// AXI4-Lite register block
// Lane configuration, commands and status
`timescale 1ns/10ps
`include "tlx_config.svh"

module tlx_csr (
  input  logic                rev_clk,
  input  logic                rst,
  input  tlx_pkg::axil_req_t  axil_req,
  output tlx_pkg::axil_rsp_t  axil_rsp,
  output tlx_pkg::lane_cfg_t  rx_cfg,
  output tlx_pkg::lane_cfg_t  tx_cfg,
  output tlx_pkg::lane_cmd_t  rx_cmd,
  output tlx_pkg::lane_cmd_t  tx_cmd,
  input  tlx_pkg::lane_stat_t rx_stat,
  input  tlx_pkg::lane_stat_t tx_stat
);
  import tlx_pkg::*;

  // Index 0 is the rx lane, 1 the tx lane
  lane_cfg_t  cfg_q [2];
  lane_cmd_t  cmd_q [2];
  lane_stat_t stat  [2];

  logic       wr_ready;
  logic       rd_ready;
  logic       bvalid;
  logic [1:0] bresp;
  logic       rvalid;
  logic [1:0] rresp;
  axil_data_t rdata;

  logic       wr_hs;
  logic       rd_hs;
  logic       wr_sel;
  logic       rd_sel;
  axil_addr_t wr_off;
  axil_addr_t rd_off;
  axil_data_t rd_val;

  function automatic logic off_mapped(axil_addr_t off);
    case (off)
      `TLX_REG_CTRL, `TLX_REG_CMD, `TLX_REG_SEQ,
      `TLX_REG_LEN, `TLX_REG_STAT, `TLX_REG_COUNT: off_mapped = 1'b1;
      default: off_mapped = 1'b0;
    endcase
  endfunction

  assign stat[0] = rx_stat;
  assign stat[1] = tx_stat;

  // Lane select and offset within the lane
  assign wr_sel = (axil_req.awaddr >= `TLX_TX_BASE);
  assign wr_off = wr_sel ? axil_req.awaddr - `TLX_TX_BASE : axil_req.awaddr - `TLX_RX_BASE;
  assign rd_sel = (axil_req.araddr >= `TLX_TX_BASE);
  assign rd_off = rd_sel ? axil_req.araddr - `TLX_TX_BASE : axil_req.araddr - `TLX_RX_BASE;

  assign wr_hs = wr_ready & axil_req.awvalid & axil_req.wvalid;
  assign rd_hs = rd_ready & axil_req.arvalid;

  //--------------------------------------------------------------------
  // Write channel
  //--------------------------------------------------------------------
  always_ff @(posedge rev_clk) begin
    if (rst) begin
      wr_ready <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      // Address and data taken together, one-cycle ready
      wr_ready <= ~wr_ready & axil_req.awvalid & axil_req.wvalid & ~bvalid;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge rev_clk) begin
    if (rst) begin
      cfg_q <= '{default: '0};
      cmd_q <= '{default: '0};
    end else begin
      cmd_q <= '{default: '0};
      if (wr_hs) begin
        case (wr_off)
          `TLX_REG_CTRL: begin
            cfg_q[wr_sel].en <= axil_req.wdata[0];
            cfg_q[wr_sel].ie <= axil_req.wdata[1];
          end
          `TLX_REG_CMD: begin
            cmd_q[wr_sel].start <= axil_req.wdata[0];
            cmd_q[wr_sel].clear <= axil_req.wdata[1];
          end
          `TLX_REG_SEQ: cfg_q[wr_sel].seq <= axil_req.wdata;
          `TLX_REG_LEN: cfg_q[wr_sel].len <= axil_req.wdata;
          default: ;
        endcase
      end
    end
  end

  //--------------------------------------------------------------------
  // Read channel
  //--------------------------------------------------------------------
  always_comb begin
    rd_val = '0;
    case (rd_off)
      `TLX_REG_CTRL: begin
        rd_val[0] = cfg_q[rd_sel].en;
        rd_val[1] = cfg_q[rd_sel].ie;
      end
      `TLX_REG_SEQ:   rd_val = cfg_q[rd_sel].seq;
      `TLX_REG_LEN:   rd_val = cfg_q[rd_sel].len;
      `TLX_REG_STAT: begin
        rd_val[0] = stat[rd_sel].active;
        rd_val[1] = stat[rd_sel].done;
      end
      `TLX_REG_COUNT: rd_val = stat[rd_sel].count;
      default:        rd_val = '0;
    endcase
  end

  always_ff @(posedge rev_clk) begin
    if (rst) begin
      rd_ready <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      rd_ready <= ~rd_ready & axil_req.arvalid & ~rvalid;
      if (rd_hs) begin
        rvalid <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Response payload, held while valid waits
  always_ff @(posedge rev_clk) begin
    if (wr_hs) begin
      bresp <= off_mapped(wr_off) ? `TLX_RESP_OKAY : `TLX_RESP_SLVERR;
    end
    if (rd_hs) begin
      rdata <= rd_val;
      rresp <= off_mapped(rd_off) ? `TLX_RESP_OKAY : `TLX_RESP_SLVERR;
    end
  end

  assign axil_rsp.awready = wr_ready;
  assign axil_rsp.wready  = wr_ready;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = bresp;
  assign axil_rsp.arready = rd_ready;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = rresp;

  assign rx_cfg = cfg_q[0];
  assign tx_cfg = cfg_q[1];
  assign rx_cmd = cmd_q[0];
  assign tx_cmd = cmd_q[1];

endmodule

//--- design/tlx_pkg.sv
// TLX shared types
`include "tlx_config.svh"

package tlx_pkg;

  typedef logic [`TLX_SEQ_W-1:0]  seq_t;
  typedef logic [`TLX_LEN_W-1:0]  len_t;
  typedef logic [`TLX_LEN_W-1:0]  count_t;
  typedef logic [`TLX_ADDR_W-1:0] axil_addr_t;
  typedef logic [`TLX_DATA_W-1:0] axil_data_t;

  //----------------------------------------------------------------------
  // Lane groups
  //----------------------------------------------------------------------
  typedef struct packed {
    logic en;
    logic ie;
    seq_t seq;
    len_t len;
  } lane_cfg_t;

  typedef struct packed {
    logic start;
    logic clear;
  } lane_cmd_t;

  typedef struct packed {
    logic   active;
    logic   done;
    count_t count;
  } lane_stat_t;

  //----------------------------------------------------------------------
  // AXI4-Lite channels
  //----------------------------------------------------------------------
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  typedef enum logic [1:0] {RX_IDLE, RX_RUN, RX_DONE} rx_state_t;
  typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

endpackage

//--- design/tlx_rev_ctrl.sv
// TLX reverse channel training controller
`timescale 1ns/10ps

module tlx_rev_ctrl (
  input  logic               rev_clk,
  input  logic               rst,
  input  tlx_pkg::axil_req_t axil_req,
  output tlx_pkg::axil_rsp_t axil_rsp,
  input  logic               rx_din,
  input  logic               tx_din,
  output logic               tx_dout,
  output logic               rx_irq,
  output logic               tx_irq
);
  import tlx_pkg::*;

  lane_cfg_t  rx_cfg;
  lane_cfg_t  tx_cfg;
  lane_cmd_t  rx_cmd;
  lane_cmd_t  tx_cmd;
  lane_stat_t rx_stat;
  lane_stat_t tx_stat;

  tlx_csr u_csr (
    .rev_clk  (rev_clk),
    .rst      (rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .rx_cfg   (rx_cfg),
    .tx_cfg   (tx_cfg),
    .rx_cmd   (rx_cmd),
    .tx_cmd   (tx_cmd),
    .rx_stat  (rx_stat),
    .tx_stat  (tx_stat)
  );

  tlx_rx_lane u_rx_lane (
    .rev_clk (rev_clk),
    .rst     (rst),
    .din     (rx_din),
    .cfg     (rx_cfg),
    .cmd     (rx_cmd),
    .stat    (rx_stat)
  );

  tlx_tx_lane u_tx_lane (
    .rev_clk (rev_clk),
    .rst     (rst),
    .din     (tx_din),
    .cfg     (tx_cfg),
    .cmd     (tx_cmd),
    .dout    (tx_dout),
    .stat    (tx_stat)
  );

  // Interrupts are the done bits
  assign rx_irq = rx_stat.done;
  assign tx_irq = tx_stat.done;

endmodule

//--- design/tlx_rx_lane.sv
// Input lane sequence matcher
`timescale 1ns/10ps
`include "tlx_config.svh"

module tlx_rx_lane (
  input  logic                rev_clk,
  input  logic                rst,
  input  logic                din,
  input  tlx_pkg::lane_cfg_t  cfg,
  input  tlx_pkg::lane_cmd_t  cmd,
  output tlx_pkg::lane_stat_t stat
);
  import tlx_pkg::*;

  rx_state_t state;
  seq_t      window;
  seq_t      window_nxt;
  len_t      bit_cnt;
  len_t      bits_nxt;
  count_t    match_cnt;
  logic      done;
  logic      start_ok;
  logic      seq_hit;

  assign start_ok   = cmd.start & cfg.en;
  assign window_nxt = {window[`TLX_SEQ_W-2:0], din};
  assign bits_nxt   = bit_cnt + 1'b1;

  // Window only counts once a full sequence has shifted in
  assign seq_hit = (bits_nxt >= len_t'(`TLX_SEQ_W)) && (window_nxt == cfg.seq);

  //--------------------------------------------------------------------
  // Control FSM
  //--------------------------------------------------------------------
  always_ff @(posedge rev_clk) begin
    if (rst) begin
      state     <= RX_IDLE;
      done      <= 1'b0;
      match_cnt <= '0;
    end else if (cmd.clear) begin
      state     <= RX_IDLE;
      done      <= 1'b0;
      match_cnt <= '0;
    end else if (start_ok) begin
      state     <= RX_RUN;
      done      <= 1'b0;
      match_cnt <= '0;
    end else if (state == RX_RUN) begin
      if (seq_hit) begin
        match_cnt <= match_cnt + 1'b1;
      end
      if (bits_nxt == cfg.len) begin
        done <= 1'b1;
        // Auto stop when the interrupt is enabled
        if (cfg.ie) begin
          state <= RX_DONE;
        end
      end
    end
  end

  // Shift window and bit counter
  always_ff @(posedge rev_clk) begin
    if (start_ok) begin
      window  <= '0;
      bit_cnt <= '0;
    end else if (state == RX_RUN) begin
      window  <= window_nxt;
      bit_cnt <= bits_nxt;
    end
  end

  assign stat.active = (state == RX_RUN);
  assign stat.done   = done;
  assign stat.count  = match_cnt;

endmodule

//--- design/tlx_tx_lane.sv
// Output lane sequence driver
`timescale 1ns/10ps
`include "tlx_config.svh"

module tlx_tx_lane (
  input  logic                rev_clk,
  input  logic                rst,
  input  logic                din,
  input  tlx_pkg::lane_cfg_t  cfg,
  input  tlx_pkg::lane_cmd_t  cmd,
  output logic                dout,
  output tlx_pkg::lane_stat_t stat
);
  import tlx_pkg::*;

  tx_state_t state;
  seq_t      shreg;
  len_t      bit_cnt;
  len_t      bits_nxt;
  logic      done;
  logic      start_ok;

  assign start_ok = cmd.start & cfg.en;
  assign bits_nxt = bit_cnt + 1'b1;

  always_ff @(posedge rev_clk) begin
    if (rst) begin
      state <= TX_IDLE;
      done  <= 1'b0;
    end else if (cmd.clear) begin
      state <= TX_IDLE;
      done  <= 1'b0;
    end else if (start_ok) begin
      state <= TX_SEND;
      done  <= 1'b0;
    end else if (state == TX_SEND && bits_nxt == cfg.len) begin
      done <= 1'b1;
      if (cfg.ie) begin
        state <= TX_IDLE;
      end
    end
  end

  // Rotate MSB first so the sequence repeats
  always_ff @(posedge rev_clk) begin
    if (start_ok) begin
      shreg   <= cfg.seq;
      bit_cnt <= '0;
    end else if (state == TX_SEND) begin
      shreg   <= {shreg[`TLX_SEQ_W-2:0], shreg[`TLX_SEQ_W-1]};
      bit_cnt <= bits_nxt;
    end
  end

  // Disabled lane passes its input through
  assign dout = cfg.en ? ((state == TX_SEND) & shreg[`TLX_SEQ_W-1]) : din;

  assign stat.active = (state == TX_SEND);
  assign stat.done   = done;
  assign stat.count  = '0;

endmodule

//--- dv/tlx_rev_ctrl_asserts.sv
// TLX bus handshake and lane status checks
`timescale 1ns/10ps

module tlx_rev_ctrl_asserts (
  input logic                rev_clk,
  input logic                rst,
  input tlx_pkg::axil_req_t  axil_req,
  input tlx_pkg::axil_rsp_t  axil_rsp,
  input tlx_pkg::lane_cfg_t  rx_cfg,
  input tlx_pkg::lane_cfg_t  tx_cfg,
  input tlx_pkg::lane_stat_t rx_stat,
  input tlx_pkg::lane_stat_t tx_stat
);

  bvalid_held: assert property (@(posedge rev_clk) disable iff (rst)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

  rvalid_held: assert property (@(posedge rev_clk) disable iff (rst)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else $error("rvalid dropped before rready");

  rdata_stable: assert property (@(posedge rev_clk) disable iff (rst)
    axil_rsp.rvalid && !axil_req.rready |=> $stable(axil_rsp.rdata))
    else $error("rdata changed while rvalid waited");

  // Auto stop means active and done never overlap
  rx_stop: assert property (@(posedge rev_clk) disable iff (rst)
    rx_cfg.ie |-> !(rx_stat.active && rx_stat.done))
    else $error("rx lane active and done together");

  tx_stop: assert property (@(posedge rev_clk) disable iff (rst)
    tx_cfg.ie |-> !(tx_stat.active && tx_stat.done))
    else $error("tx lane active and done together");

endmodule

bind tlx_rev_ctrl tlx_rev_ctrl_asserts u_asserts (
  .rev_clk  (rev_clk),
  .rst      (rst),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .rx_cfg   (rx_cfg),
  .tx_cfg   (tx_cfg),
  .rx_stat  (rx_stat),
  .tx_stat  (tx_stat)
);

//--- dv/tlx_rev_ctrl_tb.sv
// TLX reverse channel testbench
`timescale 1ns/10ps
`include "tlx_config.svh"

module tlx_rev_ctrl_tb;
  import tlx_pkg::*;

  // Longest lane run, bus operations and their cost in cycles
  localparam int MAX_LEN        = 96;
  localparam int AXI_OPS        = 48;
  localparam int AXI_OP_CYCLES  = 6;
  localparam int TIMEOUT_CYCLES = 2 * (AXI_OPS * AXI_OP_CYCLES + 4 * MAX_LEN + 120);

  logic      rev_clk;
  logic      rst;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  logic      rx_din;
  logic      tx_din;
  logic      tx_dout;
  logic      rx_irq;
  logic      tx_irq;
  int        cycles = 0;
  // Cycles that bready and rready are held off after the request
  int        resp_delay = 0;

  tlx_rev_ctrl DUT (.*);

  initial begin
    rev_clk = 1'b0;
    forever #20 rev_clk = ~rev_clk;
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "Simulation stopped");
  endtask

  always @(posedge rev_clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      stop_run($sformatf("Timeout: no result after %0d cycles", cycles));
    end
  end

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp)
      else stop_run($sformatf("Error at %0t ns: %s is %0h, expected %0h",
                              $time, what, got, exp));
  endtask

  //--------------------------------------------------------------------
  // AXI4-Lite access, called and returning on a falling edge
  //--------------------------------------------------------------------
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output logic [1:0] resp);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    @(negedge rev_clk);
    while (!axil_rsp.awready) @(negedge rev_clk);
    expect_equal("wready with awready", axil_rsp.wready, 1'b1);
    @(negedge rev_clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    repeat (resp_delay) @(negedge rev_clk);
    axil_req.bready  = 1'b1;
    while (!axil_rsp.bvalid) @(negedge rev_clk);
    resp = axil_rsp.bresp;
    @(negedge rev_clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output logic [1:0] resp);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    @(negedge rev_clk);
    while (!axil_rsp.arready) @(negedge rev_clk);
    @(negedge rev_clk);
    axil_req.arvalid = 1'b0;
    repeat (resp_delay) @(negedge rev_clk);
    axil_req.rready  = 1'b1;
    while (!axil_rsp.rvalid) @(negedge rev_clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(negedge rev_clk);
    axil_req.rready = 1'b0;
  endtask

  //--------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------
  task automatic test_registers();
    axil_addr_t offs [3];
    axil_data_t vals [6];
    axil_addr_t base;
    axil_data_t rd;
    logic [1:0] resp;
    offs = '{`TLX_REG_CTRL, `TLX_REG_SEQ, `TLX_REG_LEN};
    // Responses wait on the bus here
    resp_delay = 2;
    axil_read(`TLX_RX_BASE + `TLX_REG_STAT, rd, resp);
    expect_equal("rx STAT after reset", rd, 32'h0);
    axil_read(`TLX_TX_BASE + `TLX_REG_STAT, rd, resp);
    expect_equal("tx STAT after reset", rd, 32'h0);
    for (int i = 0; i < 6; i++) begin
      base    = (i < 3) ? `TLX_RX_BASE : `TLX_TX_BASE;
      vals[i] = $urandom;
      axil_write(base + offs[i % 3], vals[i], resp);
      expect_equal("write response", resp, `TLX_RESP_OKAY);
    end
    for (int i = 0; i < 6; i++) begin
      base = (i < 3) ? `TLX_RX_BASE : `TLX_TX_BASE;
      axil_read(base + offs[i % 3], rd, resp);
      // CTRL keeps only enable and interrupt enable
      expect_equal("register readback", rd, (i % 3 == 0) ? (vals[i] & 32'h3) : vals[i]);
    end
    axil_write(`TLX_RX_BASE + 6'h18, 32'hdead_beef, resp);
    expect_equal("unmapped write response", resp, `TLX_RESP_SLVERR);
    axil_read(`TLX_TX_BASE + 6'h1C, rd, resp);
    expect_equal("unmapped read response", resp, `TLX_RESP_SLVERR);
    expect_equal("unmapped read data", rd, 32'h0);
    resp_delay = 0;
  endtask

  task automatic run_rx(input logic din, input count_t exp_count);
    axil_data_t rd;
    logic [1:0] resp;
    rx_din = din;
    axil_write(`TLX_RX_BASE + `TLX_REG_CMD, 32'h1, resp);
    while (rx_irq) @(negedge rev_clk);
    while (!rx_irq) @(negedge rev_clk);
    axil_read(`TLX_RX_BASE + `TLX_REG_COUNT, rd, resp);
    expect_equal("rx COUNT", rd, exp_count);
    axil_read(`TLX_RX_BASE + `TLX_REG_STAT, rd, resp);
    expect_equal("rx STAT", rd, 32'h2);
  endtask

  task automatic test_rx_count(input len_t len);
    logic [1:0] resp;
    axil_write(`TLX_RX_BASE + `TLX_REG_SEQ, 32'hffff_ffff, resp);
    axil_write(`TLX_RX_BASE + `TLX_REG_LEN, len, resp);
    axil_write(`TLX_RX_BASE + `TLX_REG_CTRL, 32'h3, resp);
    // Every full window after the first 31 bits matches
    run_rx(1'b1, len - 31);
    run_rx(1'b0, '0);
  endtask

  task automatic test_rx_clear_gate(input len_t len);
    axil_data_t rd;
    logic [1:0] resp;
    axil_write(`TLX_RX_BASE + `TLX_REG_CMD, 32'h2, resp);
    axil_read(`TLX_RX_BASE + `TLX_REG_COUNT, rd, resp);
    expect_equal("rx COUNT after clear", rd, 32'h0);
    axil_read(`TLX_RX_BASE + `TLX_REG_STAT, rd, resp);
    expect_equal("rx STAT after clear", rd, 32'h0);
    expect_equal("rx_irq after clear", rx_irq, 1'b0);
    axil_write(`TLX_RX_BASE + `TLX_REG_CTRL, 32'h2, resp);
    axil_write(`TLX_RX_BASE + `TLX_REG_CMD, 32'h1, resp);
    repeat (len + 16) begin
      @(negedge rev_clk);
      assert (!rx_irq) else stop_run("rx_irq rose after a start on a disabled lane");
    end
    axil_read(`TLX_RX_BASE + `TLX_REG_STAT, rd, resp);
    expect_equal("rx STAT with lane disabled", rd, 32'h0);
  endtask

  task automatic test_tx_serial();
    seq_t       seq;
    int         k;
    int         ones;
    logic [1:0] resp;
    seq    = $urandom;
    k      = 1 + $urandom % 3;
    ones   = 0;
    tx_din = 1'b0;
    axil_write(`TLX_TX_BASE + `TLX_REG_SEQ, seq, resp);
    axil_write(`TLX_TX_BASE + `TLX_REG_LEN, 32 * k, resp);
    axil_write(`TLX_TX_BASE + `TLX_REG_CTRL, 32'h3, resp);
    axil_write(`TLX_TX_BASE + `TLX_REG_CMD, 32'h1, resp);
    while (!tx_irq) begin
      ones += tx_dout;
      @(negedge rev_clk);
    end
    expect_equal("tx ones sent", ones, k * $countones(seq));
    repeat (40) begin
      @(negedge rev_clk);
      assert (tx_dout === 1'b0) else stop_run("tx_dout not idle after the lane stopped");
    end
  endtask

  task automatic test_tx_bypass();
    logic [1:0] resp;
    axil_write(`TLX_TX_BASE + `TLX_REG_CTRL, 32'h0, resp);
    repeat (40) begin
      @(negedge rev_clk);
      tx_din = $urandom % 2;
      @(posedge rev_clk);
      expect_equal("tx_dout in bypass", tx_dout, tx_din);
    end
    @(negedge rev_clk);
  endtask

  initial begin
    len_t rx_len;
    void'($urandom(32'hfb9c_a5aa));
    rst      = 1'b1;
    axil_req = '0;
    rx_din   = 1'b0;
    tx_din   = 1'b0;
    repeat (3) @(posedge rev_clk);
    @(negedge rev_clk);
    rst    = 1'b0;
    rx_len = 32 + $urandom % 64;
    test_registers();
    test_rx_count(rx_len);
    test_rx_clear_gate(rx_len);
    test_tx_serial();
    test_tx_bypass();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the TLX reverse channel simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
  --top-module tlx_rev_ctrl_tb -f vlog.f -o tlx_rev_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tlx_rev_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0

//--- vlog.f
+incdir+design
design/tlx_pkg.sv
design/tlx_csr.sv
design/tlx_rx_lane.sv
design/tlx_tx_lane.sv
design/tlx_rev_ctrl.sv
dv/tlx_rev_ctrl_asserts.sv
dv/tlx_rev_ctrl_tb.sv
